/* files.f */
fpu_ss_pkg.sv
fpu_ss_offload_if.sv
fpu_ss_issue_decoder.sv
fpu_ss_issue_fifo.sv
fpu_ss_regfile.sv
fpu_ss_bitops.sv
fpu_ss_controller.sv
fpu_ss.sv
tb_fpu_ss.sv

/* fpu_ss.sv */
// fpu subsystem top level that offloads F-extension bit-manipulation and load/store instructions
`timescale 1ns/10ps

module fpu_ss #(
  parameter int unsigned FIFO_DEPTH = fpu_ss_pkg::FIFO_DEPTH_DEFAULT
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // issue port
  input  logic                  x_issue_valid_i,
  output logic                  x_issue_ready_o,
  input  fpu_ss_pkg::word_t     x_issue_instr_i,
  input  fpu_ss_pkg::word_t     x_issue_rs1_i,
  input  logic                  x_issue_rs1_valid_i,
  input  fpu_ss_pkg::xid_t      x_issue_id_i,
  output logic                  x_issue_accept_o,
  output logic                  x_issue_writeback_o,
  output logic                  x_issue_loadstore_o,
  // memory request and result
  output logic                  x_mem_valid_o,
  input  logic                  x_mem_ready_i,
  output fpu_ss_pkg::word_t     x_mem_addr_o,
  output logic                  x_mem_we_o,
  output fpu_ss_pkg::word_t     x_mem_wdata_o,
  output fpu_ss_pkg::xid_t      x_mem_id_o,
  input  logic                  x_mem_result_valid_i,
  input  fpu_ss_pkg::word_t     x_mem_result_rdata_i,
  // integer result
  output logic                  x_result_valid_o,
  input  logic                  x_result_ready_i,
  output fpu_ss_pkg::word_t     x_result_data_o,
  output fpu_ss_pkg::fpr_addr_t x_result_rd_o,
  output fpu_ss_pkg::xid_t      x_result_id_o
);
  import fpu_ss_pkg::*;

  fpr_addr_t rf_raddr_a;
  fpr_addr_t rf_raddr_b;
  fpr_addr_t rf_waddr;
  word_t     rf_rdata_a;
  word_t     rf_rdata_b;
  logic      rf_we;
  word_t     rf_wdata;
  logic      bitops_en;
  word_t     bitops_result;

  // decoder to buffer, buffer to controller
  fpu_ss_offload_if push_if ();
  fpu_ss_offload_if pop_if ();

  fpu_ss_issue_decoder i_issue_decoder (
    .x_issue_valid_i     (x_issue_valid_i),
    .x_issue_rs1_valid_i (x_issue_rs1_valid_i),
    .x_issue_instr_i     (x_issue_instr_i),
    .x_issue_rs1_i       (x_issue_rs1_i),
    .x_issue_id_i        (x_issue_id_i),
    .x_issue_ready_o     (x_issue_ready_o),
    .x_issue_accept_o    (x_issue_accept_o),
    .x_issue_writeback_o (x_issue_writeback_o),
    .x_issue_loadstore_o (x_issue_loadstore_o),
    .push_if             (push_if.source)
  );

  fpu_ss_issue_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_issue_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_if (push_if.sink),
    .pop_if  (pop_if.source)
  );

  fpu_ss_regfile i_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .waddr_i   (rf_waddr),
    .we_i      (rf_we),
    .wdata_i   (rf_wdata)
  );

  // bitops reads the buffer head directly, it registers on the pop
  fpu_ss_bitops i_bitops (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .en_i     (bitops_en),
    .op_i     (pop_if.op),
    .a_i      (rf_rdata_a),
    .b_i      (rf_rdata_b),
    .int_i    (pop_if.int_op),
    .result_o (bitops_result)
  );

  fpu_ss_controller i_controller (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .pop_if               (pop_if.sink),
    .rf_raddr_a_o         (rf_raddr_a),
    .rf_raddr_b_o         (rf_raddr_b),
    .rf_waddr_o           (rf_waddr),
    .rf_rdata_b_i         (rf_rdata_b),
    .rf_we_o              (rf_we),
    .rf_wdata_o           (rf_wdata),
    .bitops_en_o          (bitops_en),
    .bitops_result_i      (bitops_result),
    .x_mem_valid_o        (x_mem_valid_o),
    .x_mem_ready_i        (x_mem_ready_i),
    .x_mem_addr_o         (x_mem_addr_o),
    .x_mem_we_o           (x_mem_we_o),
    .x_mem_wdata_o        (x_mem_wdata_o),
    .x_mem_id_o           (x_mem_id_o),
    .x_mem_result_valid_i (x_mem_result_valid_i),
    .x_mem_result_rdata_i (x_mem_result_rdata_i),
    .x_result_valid_o     (x_result_valid_o),
    .x_result_ready_i     (x_result_ready_i),
    .x_result_data_o      (x_result_data_o),
    .x_result_rd_o        (x_result_rd_o),
    .x_result_id_o        (x_result_id_o)
  );

endmodule

/* fpu_ss_bitops.sv */
// registered bit-manipulation unit for sign injection, fclass and moves
`timescale 1ns/10ps

module fpu_ss_bitops (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               en_i,
  input  fpu_ss_pkg::fp_op_e op_i,
  input  fpu_ss_pkg::word_t  a_i,
  input  fpu_ss_pkg::word_t  b_i,
  input  fpu_ss_pkg::word_t  int_i,
  output fpu_ss_pkg::word_t  result_o
);
  import fpu_ss_pkg::*;

  logic    exp_ones;
  logic    exp_zero;
  logic    man_zero;
  logic    is_nan;
  logic    is_norm;
  fclass_t class_mask;
  word_t   result_d;
  word_t   result_q;

  // single precision field decode of operand a
  assign exp_ones = &a_i[30:23];
  assign exp_zero = ~|a_i[30:23];
  assign man_zero = ~|a_i[22:0];
  assign is_nan   = exp_ones && !man_zero;
  assign is_norm  = !exp_ones && !exp_zero;

  // one-hot class, negative classes in the low half
  assign class_mask[0] = a_i[31] && exp_ones && man_zero;
  assign class_mask[1] = a_i[31] && is_norm;
  assign class_mask[2] = a_i[31] && exp_zero && !man_zero;
  assign class_mask[3] = a_i[31] && exp_zero && man_zero;
  assign class_mask[4] = !a_i[31] && exp_zero && man_zero;
  assign class_mask[5] = !a_i[31] && exp_zero && !man_zero;
  assign class_mask[6] = !a_i[31] && is_norm;
  assign class_mask[7] = !a_i[31] && exp_ones && man_zero;
  // quiet bit is the mantissa msb
  assign class_mask[8] = is_nan && !a_i[22];
  assign class_mask[9] = is_nan && a_i[22];

  always_comb begin
    unique case (op_i)
      OP_FSGNJ:   result_d = {b_i[31], a_i[30:0]};
      OP_FSGNJN:  result_d = {~b_i[31], a_i[30:0]};
      OP_FSGNJX:  result_d = {a_i[31] ^ b_i[31], a_i[30:0]};
      OP_FCLASS:  result_d = {22'b0, class_mask};
      OP_FMV_W_X: result_d = int_i;
      // fmv.x.w passes the raw bits, memory ops leave it unused
      default:    result_d = a_i;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_q <= '0;
    end else if (en_i) begin
      result_q <= result_d;
    end
  end

  assign result_o = result_q;

endmodule

/* fpu_ss_controller.sv */
// controller FSM sequencing one instruction at a time through regfile, bitops, memory and result
`timescale 1ns/10ps

module fpu_ss_controller (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  fpu_ss_offload_if.sink        pop_if,
  output fpu_ss_pkg::fpr_addr_t rf_raddr_a_o,
  output fpu_ss_pkg::fpr_addr_t rf_raddr_b_o,
  output fpu_ss_pkg::fpr_addr_t rf_waddr_o,
  input  fpu_ss_pkg::word_t     rf_rdata_b_i,
  output logic                  rf_we_o,
  output fpu_ss_pkg::word_t     rf_wdata_o,
  output logic                  bitops_en_o,
  input  fpu_ss_pkg::word_t     bitops_result_i,
  output logic                  x_mem_valid_o,
  input  logic                  x_mem_ready_i,
  output fpu_ss_pkg::word_t     x_mem_addr_o,
  output logic                  x_mem_we_o,
  output fpu_ss_pkg::word_t     x_mem_wdata_o,
  output fpu_ss_pkg::xid_t      x_mem_id_o,
  input  logic                  x_mem_result_valid_i,
  input  fpu_ss_pkg::word_t     x_mem_result_rdata_i,
  output logic                  x_result_valid_o,
  input  logic                  x_result_ready_i,
  output fpu_ss_pkg::word_t     x_result_data_o,
  output fpu_ss_pkg::fpr_addr_t x_result_rd_o,
  output fpu_ss_pkg::xid_t      x_result_id_o
);
  import fpu_ss_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        pop;
  // instruction latched at the pop
  fp_op_e      op_q;
  fpr_addr_t   rd_q;
  fpr_addr_t   rs2_q;
  word_t       int_op_q;
  word_t       offset_q;
  xid_t        id_q;
  // payloads held under back-pressure
  word_t       result_q;
  word_t       mem_wdata_q;

  assign pop           = pop_if.valid && pop_if.ready;
  assign pop_if.ready  = (state_q == ST_IDLE);
  // bitops samples the head entry on the pop edge
  assign bitops_en_o   = pop;
  assign rf_raddr_a_o  = pop_if.rs1;
  assign rf_raddr_b_o  = (state_q == ST_IDLE) ? pop_if.rs2 : rs2_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (pop_if.valid) begin
          state_d = ST_EXEC;
        end
      end
      ST_EXEC: begin
        unique case (op_q)
          OP_FMV_X_W, OP_FCLASS: state_d = ST_RESULT;
          OP_FLW, OP_FSW:        state_d = ST_MEM_REQ;
          default:               state_d = ST_IDLE;
        endcase
      end
      ST_RESULT: begin
        if (x_result_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      ST_MEM_REQ: begin
        if (x_mem_ready_i) begin
          state_d = ST_MEM_WAIT;
        end
      end
      ST_MEM_WAIT: begin
        if (x_mem_result_valid_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      op_q     <= pop_if.op;
      rd_q     <= pop_if.rd;
      rs2_q    <= pop_if.rs2;
      int_op_q <= pop_if.int_op;
      offset_q <= pop_if.offset;
      id_q     <= pop_if.id;
    end
    // bitops output and store data are both ready during exec
    if (state_q == ST_EXEC) begin
      result_q    <= bitops_result_i;
      mem_wdata_q <= rf_rdata_b_i;
    end
  end

  // register write at the end of exec, or when load data returns
  assign rf_waddr_o = rd_q;
  assign rf_we_o    = ((state_q == ST_EXEC) &&
                       (op_q inside {OP_FSGNJ, OP_FSGNJN, OP_FSGNJX, OP_FMV_W_X})) ||
                      ((state_q == ST_MEM_WAIT) && x_mem_result_valid_i && (op_q == OP_FLW));
  assign rf_wdata_o = (state_q == ST_MEM_WAIT) ? x_mem_result_rdata_i : bitops_result_i;

  // memory request, base plus immediate
  assign x_mem_valid_o = (state_q == ST_MEM_REQ);
  assign x_mem_addr_o  = int_op_q + offset_q;
  assign x_mem_we_o    = (op_q == OP_FSW);
  assign x_mem_wdata_o = mem_wdata_q;
  assign x_mem_id_o    = id_q;

  // integer result back to the core
  assign x_result_valid_o = (state_q == ST_RESULT);
  assign x_result_data_o  = result_q;
  assign x_result_rd_o    = rd_q;
  assign x_result_id_o    = id_q;

  // a stalled result keeps its payload until the core takes it
  a_result_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      x_result_valid_o && !x_result_ready_i |=> x_result_valid_o &&
      $stable(x_result_data_o) && $stable(x_result_rd_o) && $stable(x_result_id_o));

endmodule

/* fpu_ss_issue_decoder.sv */
// issue decoder that answers the offload request and pushes accepted instructions
`timescale 1ns/10ps

module fpu_ss_issue_decoder (
  input  logic               x_issue_valid_i,
  input  logic               x_issue_rs1_valid_i,
  input  fpu_ss_pkg::word_t  x_issue_instr_i,
  input  fpu_ss_pkg::word_t  x_issue_rs1_i,
  input  fpu_ss_pkg::xid_t   x_issue_id_i,
  output logic               x_issue_ready_o,
  output logic               x_issue_accept_o,
  output logic               x_issue_writeback_o,
  output logic               x_issue_loadstore_o,
  fpu_ss_offload_if.source   push_if
);
  import fpu_ss_pkg::*;

  // funct7 groups of the OP-FP forms
  localparam logic [6:0] F7_FSGNJ   = 7'b001_0000;
  localparam logic [6:0] F7_FMV_X_W = 7'b111_0000;
  localparam logic [6:0] F7_FMV_W_X = 7'b111_1000;

  logic   supported;
  logic   needs_int;
  logic   rs1_ok;
  fp_op_e op;

  always_comb begin
    supported = 1'b0;
    needs_int = 1'b0;
    op        = OP_FMV_W_X;
    unique case (x_issue_instr_i[6:0])
      OPCODE_OP_FP: begin
        // sign injection picks its flavour by funct3
        if (x_issue_instr_i[31:25] == F7_FSGNJ) begin
          supported = (x_issue_instr_i[14:12] <= 3'b010);
          case (x_issue_instr_i[14:12])
            3'b000:  op = OP_FSGNJ;
            3'b001:  op = OP_FSGNJN;
            default: op = OP_FSGNJX;
          endcase
        end else if (x_issue_instr_i[31:25] == F7_FMV_X_W && x_issue_instr_i[24:20] == '0) begin
          // fmv.x.w and fclass.s share funct7
          supported = (x_issue_instr_i[14:12] <= 3'b001);
          op        = x_issue_instr_i[12] ? OP_FCLASS : OP_FMV_X_W;
        end else if (x_issue_instr_i[31:25] == F7_FMV_W_X && x_issue_instr_i[24:20] == '0) begin
          supported = (x_issue_instr_i[14:12] == 3'b000);
          needs_int = 1'b1;
          op        = OP_FMV_W_X;
        end
      end
      OPCODE_LOAD_FP: begin
        supported = (x_issue_instr_i[14:12] == FUNCT3_W);
        needs_int = 1'b1;
        op        = OP_FLW;
      end
      OPCODE_STORE_FP: begin
        supported = (x_issue_instr_i[14:12] == FUNCT3_W);
        needs_int = 1'b1;
        op        = OP_FSW;
      end
      default: ;
    endcase
  end

  // issue answer, straight from the instruction word
  assign x_issue_accept_o    = supported;
  assign x_issue_writeback_o = supported && (op == OP_FMV_X_W || op == OP_FCLASS);
  assign x_issue_loadstore_o = supported && (op == OP_FLW || op == OP_FSW);

  // an unaccepted word still handshakes but never reaches the buffer
  assign rs1_ok          = !needs_int || x_issue_rs1_valid_i;
  assign x_issue_ready_o = push_if.ready && rs1_ok;
  assign push_if.valid   = x_issue_valid_i && supported && rs1_ok;

  assign push_if.op     = op;
  assign push_if.rd     = x_issue_instr_i[11:7];
  assign push_if.rs1    = x_issue_instr_i[19:15];
  assign push_if.rs2    = x_issue_instr_i[24:20];
  assign push_if.int_op = x_issue_rs1_i;
  assign push_if.id     = x_issue_id_i;
  // S-type immediate for fsw, I-type for everything else
  assign push_if.offset = (x_issue_instr_i[6:0] == OPCODE_STORE_FP) ?
      {{20{x_issue_instr_i[31]}}, x_issue_instr_i[31:25], x_issue_instr_i[11:7]} :
      {{20{x_issue_instr_i[31]}}, x_issue_instr_i[31:20]};

endmodule

/* fpu_ss_issue_fifo.sv */
// in-order issue buffer of decoded instructions with valid/ready on both sides
`timescale 1ns/10ps

module fpu_ss_issue_fifo #(
  parameter int unsigned FIFO_DEPTH = fpu_ss_pkg::FIFO_DEPTH_DEFAULT
) (
  input logic              clk_i,
  input logic              rst_ni,
  fpu_ss_offload_if.sink   push_if,
  fpu_ss_offload_if.source pop_if
);
  import fpu_ss_pkg::*;

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  // entry storage, one array per field
  fp_op_e     op_q     [FIFO_DEPTH];
  fpr_addr_t  rd_q     [FIFO_DEPTH];
  fpr_addr_t  rs1_q    [FIFO_DEPTH];
  fpr_addr_t  rs2_q    [FIFO_DEPTH];
  word_t      int_op_q [FIFO_DEPTH];
  word_t      offset_q [FIFO_DEPTH];
  xid_t       id_q     [FIFO_DEPTH];
  logic [PTR_W-1:0] wptr_q;
  logic [PTR_W-1:0] rptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_d;
  logic             full_q;
  logic             push;
  logic             pop;

  // wrap at the depth, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push          = push_if.valid && push_if.ready;
  assign pop           = pop_if.valid && pop_if.ready;
  assign count_d       = count_q + CNT_W'(push) - CNT_W'(pop);
  // registered full flag, held high during reset so issue stays closed
  assign push_if.ready = !full_q;
  assign pop_if.valid  = (count_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
      full_q  <= 1'b1;
    end else begin
      if (push) begin
        wptr_q <= ptr_inc(wptr_q);
      end
      if (pop) begin
        rptr_q <= ptr_inc(rptr_q);
      end
      count_q <= count_d;
      full_q  <= (count_d == CNT_W'(FIFO_DEPTH));
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      op_q[wptr_q]     <= push_if.op;
      rd_q[wptr_q]     <= push_if.rd;
      rs1_q[wptr_q]    <= push_if.rs1;
      rs2_q[wptr_q]    <= push_if.rs2;
      int_op_q[wptr_q] <= push_if.int_op;
      offset_q[wptr_q] <= push_if.offset;
      id_q[wptr_q]     <= push_if.id;
    end
  end

  // head entry, registered storage so nothing falls through
  assign pop_if.op     = op_q[rptr_q];
  assign pop_if.rd     = rd_q[rptr_q];
  assign pop_if.rs1    = rs1_q[rptr_q];
  assign pop_if.rs2    = rs2_q[rptr_q];
  assign pop_if.int_op = int_op_q[rptr_q];
  assign pop_if.offset = offset_q[rptr_q];
  assign pop_if.id     = id_q[rptr_q];

  // a full buffer that is not drained takes no new entry
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (count_q == CNT_W'(FIFO_DEPTH)) && !pop |=> $stable(wptr_q) && $stable(count_q));
  // a pop only takes an entry that the pointers still hold
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
      pop |-> (rptr_q != wptr_q) || full_q);

endmodule

/* fpu_ss_offload_if.sv */
// offload interface carrying one decoded instruction with a valid/ready handshake
`timescale 1ns/10ps

interface fpu_ss_offload_if;
  import fpu_ss_pkg::*;

  logic      valid;
  logic      ready;
  fp_op_e    op;
  fpr_addr_t rd;
  fpr_addr_t rs1;
  fpr_addr_t rs2;
  // integer rs1 value from the core
  word_t     int_op;
  // sign-extended load or store immediate
  word_t     offset;
  xid_t      id;

  modport source(output valid, op, rd, rs1, rs2, int_op, offset, id, input ready);
  modport sink(input valid, op, rd, rs1, rs2, int_op, offset, id, output ready);

endinterface

/* fpu_ss_pkg.sv */
// fpu subsystem package with shared widths, operation and state encodings, and field constants
package fpu_ss_pkg;

  // integer or single precision data word
  typedef logic [31:0] word_t;

  // floating-point register index
  typedef logic [4:0] fpr_addr_t;

  // offload transaction id, as handed over by the core
  typedef logic [3:0] xid_t;

  // fclass.s result mask
  typedef logic [9:0] fclass_t;

  // decoded operation of one accepted instruction
  typedef enum logic [2:0] {
    OP_FMV_W_X,
    OP_FMV_X_W,
    OP_FSGNJ,
    OP_FSGNJN,
    OP_FSGNJX,
    OP_FCLASS,
    OP_FLW,
    OP_FSW
  } fp_op_e;

  // controller FSM states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_EXEC,
    ST_RESULT,
    ST_MEM_REQ,
    ST_MEM_WAIT
  } ctrl_state_e;

  // major opcodes of the F extension forms handled here
  localparam logic [6:0] OPCODE_OP_FP    = 7'b101_0011;
  localparam logic [6:0] OPCODE_LOAD_FP  = 7'b000_0111;
  localparam logic [6:0] OPCODE_STORE_FP = 7'b010_0111;

  // width field of flw and fsw, word only
  localparam logic [2:0] FUNCT3_W = 3'b010;

  // default number of buffered instructions
  localparam int unsigned FIFO_DEPTH_DEFAULT = 4;

endpackage

/* fpu_ss_regfile.sv */
// floating-point register file, 32 words, two read ports and one write port
`timescale 1ns/10ps

module fpu_ss_regfile (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  fpu_ss_pkg::fpr_addr_t raddr_a_i,
  input  fpu_ss_pkg::fpr_addr_t raddr_b_i,
  output fpu_ss_pkg::word_t     rdata_a_o,
  output fpu_ss_pkg::word_t     rdata_b_o,
  input  fpu_ss_pkg::fpr_addr_t waddr_i,
  input  logic                  we_i,
  input  fpu_ss_pkg::word_t     wdata_i
);
  import fpu_ss_pkg::*;

  word_t regs_q [32];

  // all registers start at +0.0
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // combinational reads, no bypass of a same-cycle write
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

/* run.sh */
#!/usr/bin/env bash
# build the fpu subsystem testbench with Verilator, run it and look for the pass line
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fpu_ss -f files.f -o tb_fpu_ss
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_fpu_ss)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1

/* tb_fpu_ss.sv */
// testbench for the fpu subsystem, offloads instructions and checks results and memory traffic
`timescale 1ns/10ps

module tb_fpu_ss;
  import fpu_ss_pkg::*;

  localparam logic [31:0] SEED = 32'h1309_0734;
  // about 70 instructions, each well under 40 cycles with random stalls, plus margin
  localparam int TIMEOUT_CYCLES = 4000;

  // expected integer result
  typedef struct packed {
    word_t     data;
    fpr_addr_t rd;
    xid_t      id;
  } exp_res_t;

  // expected memory request and the data returned for it
  typedef struct packed {
    logic  we;
    word_t addr;
    word_t wdata;
    xid_t  id;
    word_t rdata;
  } exp_mem_t;

  logic      clk_i;
  logic      rst_ni;
  logic      x_issue_valid_i;
  logic      x_issue_ready_o;
  word_t     x_issue_instr_i;
  word_t     x_issue_rs1_i;
  logic      x_issue_rs1_valid_i;
  xid_t      x_issue_id_i;
  logic      x_issue_accept_o;
  logic      x_issue_writeback_o;
  logic      x_issue_loadstore_o;
  logic      x_mem_valid_o;
  logic      x_mem_ready_i;
  word_t     x_mem_addr_o;
  logic      x_mem_we_o;
  word_t     x_mem_wdata_o;
  xid_t      x_mem_id_o;
  logic      x_mem_result_valid_i;
  word_t     x_mem_result_rdata_i;
  logic      x_result_valid_o;
  logic      x_result_ready_i;
  word_t     x_result_data_o;
  fpr_addr_t x_result_rd_o;
  xid_t      x_result_id_o;

  exp_res_t    res_q [$];
  exp_mem_t    mem_q [$];
  string       cur_test;
  int          err_count;
  int          sva_errors;
  int          tests_run;
  int          cycle;
  logic [31:0] rng_main;
  logic [31:0] rng_resp;
  // result ready forced low, and a window where the DUT must stay silent
  logic        hold_result;
  logic        quiet;
  // load or store response still owed by the memory model
  logic        mem_pending;
  word_t       mem_pend_data;
  int          mem_pend_delay;
  xid_t        next_id;

  fpu_ss #(
    .FIFO_DEPTH (4)
  ) i_fpu_ss (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_main();
    rng_main = xorshift(rng_main);
    return rng_main;
  endfunction

  // OP-FP encoding, opcode 1010011
  function automatic word_t op_fp(input logic [6:0] f7, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3,
                                  input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b101_0011};
  endfunction

  task automatic check_val(input string what, input word_t exp, input word_t act);
    assert (act === exp) else begin
      $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  // offer one instruction until the handshake, then check the issue answer
  task automatic issue(input word_t instr, input word_t rs1_val, input logic exp_accept,
                       input logic exp_wb, input logic exp_ls);
    x_issue_valid_i = 1'b1;
    x_issue_instr_i = instr;
    x_issue_rs1_i   = rs1_val;
    x_issue_id_i    = next_id;
    @(negedge clk_i);
    while (!x_issue_ready_o) begin
      @(negedge clk_i);
    end
    check_val("accept", 32'(exp_accept), 32'(x_issue_accept_o));
    check_val("writeback", 32'(exp_wb), 32'(x_issue_writeback_o));
    check_val("loadstore", 32'(exp_ls), 32'(x_issue_loadstore_o));
    @(posedge clk_i);
    #1;
    x_issue_valid_i = 1'b0;
    next_id++;
  endtask

  // fmv.w.x
  task automatic write_reg(input fpr_addr_t r, input word_t v);
    issue(op_fp(7'b111_1000, 5'd0, 5'd3, 3'b000, r), v, 1'b1, 1'b0, 1'b0);
  endtask

  // fmv.x.w, or fclass.s when is_class is set
  task automatic read_back(input fpr_addr_t r, input word_t exp, input logic is_class);
    fpr_addr_t xrd;
    xrd = fpr_addr_t'(rand_main());
    res_q.push_back(exp_res_t'{exp, xrd, next_id});
    issue(op_fp(7'b111_0000, 5'd0, r, {2'b00, is_class}, xrd), rand_main(),
          1'b1, 1'b1, 1'b0);
  endtask

  task automatic wait_idle();
    do begin
      @(negedge clk_i);
    end while (res_q.size() != 0 || mem_q.size() != 0 || mem_pending);
    @(posedge clk_i);
    #1;
  endtask

  task automatic end_test(input int errs_before);
    tests_run++;
    $display("test %s done, %0d errors", cur_test, err_count + sva_errors - errs_before);
  endtask

  // scoreboard, memory model and random ready, all in one process
  initial begin : responder
    exp_res_t r;
    exp_mem_t m;
    forever begin
      @(negedge clk_i);
      if (x_result_valid_o && x_result_ready_i) begin
        if (res_q.size() == 0) begin
          $display("DUT returned a result with id %h that was never expected", x_result_id_o);
          err_count++;
        end else begin
          r = res_q.pop_front();
          check_val("result data", r.data, x_result_data_o);
          check_val("result rd", 32'(r.rd), 32'(x_result_rd_o));
          check_val("result id", 32'(r.id), 32'(x_result_id_o));
        end
      end
      if (x_mem_valid_o && x_mem_ready_i) begin
        if (mem_q.size() == 0) begin
          $display("DUT sent a memory request to %h that was never expected", x_mem_addr_o);
          err_count++;
        end else begin
          m = mem_q.pop_front();
          check_val("mem we", 32'(m.we), 32'(x_mem_we_o));
          check_val("mem addr", m.addr, x_mem_addr_o);
          check_val("mem id", 32'(m.id), 32'(x_mem_id_o));
          if (m.we) begin
            check_val("mem wdata", m.wdata, x_mem_wdata_o);
          end
          mem_pending    = 1'b1;
          mem_pend_data  = m.rdata;
          mem_pend_delay = int'(rng_resp[4:2]);
        end
      end
      @(posedge clk_i);
      #1;
      rng_resp         = xorshift(rng_resp);
      x_result_ready_i = !hold_result && rng_resp[0];
      x_mem_ready_i    = rng_resp[1];
      // response after 0 to 7 cycles, one cycle wide
      if (mem_pending && mem_pend_delay == 0) begin
        x_mem_result_valid_i = 1'b1;
        x_mem_result_rdata_i = mem_pend_data;
        mem_pending          = 1'b0;
      end else begin
        x_mem_result_valid_i = 1'b0;
        if (mem_pending) begin
          mem_pend_delay--;
        end
      end
    end
  end

  a_result_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      x_result_valid_o && !x_result_ready_i |=> x_result_valid_o &&
      $stable(x_result_data_o) && $stable(x_result_rd_o) && $stable(x_result_id_o))
    else begin
      $display("result payload changed while stalled in %s", cur_test);
      sva_errors++;
    end

  a_mem_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      x_mem_valid_o && !x_mem_ready_i |=> x_mem_valid_o && $stable(x_mem_addr_o) &&
      $stable(x_mem_we_o) && $stable(x_mem_wdata_o) && $stable(x_mem_id_o))
    else begin
      $display("memory request changed while stalled in %s", cur_test);
      sva_errors++;
    end

  a_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
      quiet |-> !x_mem_valid_o && !x_result_valid_o)
    else begin
      $display("DUT became active after a rejected instruction");
      sva_errors++;
    end

  initial begin : watchdog
    cycle = 0;
    while (cycle < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle++;
    end
    $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("tests failed");
    $finish;
  end

  initial begin : main
    word_t       a;
    word_t       b;
    word_t       v;
    word_t       base;
    word_t       f3_val;
    fpr_addr_t   r;
    logic [11:0] imm;
    int          errs;
    word_t       class_word [10];
    word_t       vals [5];
    rst_ni               = 1'b0;
    x_issue_valid_i      = 1'b0;
    x_issue_instr_i      = '0;
    x_issue_rs1_i        = '0;
    x_issue_rs1_valid_i  = 1'b1;
    x_issue_id_i         = '0;
    x_mem_ready_i        = 1'b0;
    x_mem_result_valid_i = 1'b0;
    x_mem_result_rdata_i = '0;
    x_result_ready_i     = 1'b0;
    hold_result          = 1'b0;
    quiet                = 1'b0;
    mem_pending          = 1'b0;
    mem_pend_data        = '0;
    mem_pend_delay       = 0;
    err_count            = 0;
    sva_errors           = 0;
    tests_run            = 0;
    next_id              = '0;
    rng_main             = SEED;
    rng_resp             = xorshift(SEED);
    cur_test             = "reset";
    // -inf, -normal, -subnormal, -0, +0, +subnormal, +normal, +inf, sNaN, qNaN
    class_word = '{32'hFF80_0000, 32'hBF80_0000, 32'h8000_0001, 32'h8000_0000,
                   32'h0000_0000, 32'h007F_FFFF, 32'h3F80_0000, 32'h7F80_0000,
                   32'h7F80_0001, 32'h7FC0_0000};
    repeat (5) @(posedge clk_i);
    #1;
    check_val("issue ready in reset", 32'h0, 32'(x_issue_ready_o));
    check_val("mem valid in reset", 32'h0, 32'(x_mem_valid_o));
    check_val("result valid in reset", 32'h0, 32'(x_result_valid_o));
    rst_ni = 1'b1;

    cur_test = "move_round_trip";
    errs = err_count + sva_errors;
    for (int i = 0; i < 4; i++) begin
      r = fpr_addr_t'(rand_main());
      v = rand_main();
      write_reg(r, v);
      read_back(r, v, 1'b0);
    end
    wait_idle();
    end_test(errs);

    // magnitude of f1, sign from f2 by the injection rule
    cur_test = "sign_injection";
    errs = err_count + sva_errors;
    for (int j = 0; j < 2; j++) begin
      a = rand_main();
      b = rand_main();
      write_reg(5'd1, a);
      write_reg(5'd2, b);
      for (int k = 0; k < 3; k++) begin
        issue(op_fp(7'b001_0000, 5'd2, 5'd1, 3'(k), 5'd3), rand_main(), 1'b1, 1'b0, 1'b0);
        case (k)
          0:       v = (a & 32'h7FFF_FFFF) | (b & 32'h8000_0000);
          1:       v = (a & 32'h7FFF_FFFF) | (~b & 32'h8000_0000);
          default: v = (a & 32'h7FFF_FFFF) | ((a ^ b) & 32'h8000_0000);
        endcase
        read_back(5'd3, v, 1'b0);
      end
    end
    f3_val = v;
    wait_idle();
    end_test(errs);

    cur_test = "fclass";
    errs = err_count + sva_errors;
    for (int i = 0; i < 10; i++) begin
      write_reg(5'd4, class_word[i]);
      read_back(5'd4, 32'(1) << i, 1'b1);
    end
    wait_idle();
    end_test(errs);

    // flw f9, imm(x7) then read f9; fsw f12, imm(x8)
    cur_test = "memory_ops";
    errs = err_count + sva_errors;
    for (int j = 0; j < 3; j++) begin
      base = rand_main();
      imm  = 12'(rand_main());
      v    = rand_main();
      mem_q.push_back(exp_mem_t'{1'b0, base + {{20{imm[11]}}, imm}, 32'h0, next_id, v});
      issue({imm, 5'd7, 3'b010, 5'd9, 7'b000_0111}, base, 1'b1, 1'b0, 1'b1);
      read_back(5'd9, v, 1'b0);
      v = rand_main();
      write_reg(5'd12, v);
      base = rand_main();
      imm  = 12'(rand_main());
      mem_q.push_back(exp_mem_t'{1'b1, base + {{20{imm[11]}}, imm}, v, next_id, 32'h0});
      issue({imm[11:5], 5'd12, 5'd8, 3'b010, imm[4:0], 7'b010_0111}, base,
            1'b1, 1'b0, 1'b1);
    end
    wait_idle();
    end_test(errs);

    // fadd.s f3 and fld f3 are rejected, f3 keeps its value
    cur_test = "unsupported";
    errs = err_count + sva_errors;
    quiet = 1'b1;
    issue(op_fp(7'b000_0000, 5'd2, 5'd1, 3'b000, 5'd3), 32'h0, 1'b0, 1'b0, 1'b0);
    issue({12'h010, 5'd7, 3'b011, 5'd3, 7'b000_0111}, 32'h0, 1'b0, 1'b0, 1'b0);
    // observation window
    repeat (10) @(posedge clk_i);
    #1;
    quiet = 1'b0;
    read_back(5'd3, f3_val, 1'b0);
    wait_idle();
    end_test(errs);

    // one result stalls in the controller, four more fill the buffer
    cur_test = "back_pressure";
    errs = err_count + sva_errors;
    for (int i = 0; i < 5; i++) begin
      vals[i] = rand_main();
      write_reg(fpr_addr_t'(20 + i), vals[i]);
    end
    @(negedge clk_i);
    hold_result = 1'b1;
    @(posedge clk_i);
    #1;
    for (int i = 0; i < 5; i++) begin
      read_back(fpr_addr_t'(20 + i), vals[i], 1'b0);
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_val("issue ready with full buffer", 32'h0, 32'(x_issue_ready_o));
    @(posedge clk_i);
    #1;
    fork
      read_back(5'd20, vals[0], 1'b0);
      begin
        repeat (6) @(negedge clk_i);
        hold_result = 1'b0;
      end
    join
    wait_idle();
    end_test(errs);

    $display("%0d tests run, %0d check errors", tests_run, err_count + sva_errors);
    if (err_count + sva_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
